/* project.f */
+incdir+rtl
rtl/ramio_pkg.sv
rtl/burst_pkg.sv
rtl/ramio_if.sv
rtl/burst_if.sv
rtl/flash_loader.sv
rtl/ramio.sv
rtl/burst_arbiter.sv
rtl/burst_ram.sv
rtl/mem_top.sv
tests/tb_mem_top.sv

/* rtl/burst_arbiter.sv */
// ---------------------------------------------------------------------
// shares the burst ram between flash loader and ramio
// fixed priority to the loader, one transaction in flight at a time
// ---------------------------------------------------------------------
module burst_arbiter
  import burst_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  burst_if.slave  loader,
  burst_if.slave  core_side,
  burst_if.master ram
);

  br_owner_e owner;
  br_cmd_e   last_cmd;     // command of the granted transaction
  logic      use_loader;   // mux select toward the ram

  assign use_loader = (owner == OWN_NONE) ? loader.req : (owner == OWN_LOADER);

  // grant only while free, loader first
  assign ram.req       = (owner == OWN_NONE) && (loader.req || core_side.req);
  assign loader.gnt    = ram.gnt && loader.req;
  assign core_side.gnt = ram.gnt && !loader.req && core_side.req;

  // command mux, strobe passes in the grant cycle
  assign ram.cmd       = use_loader ? loader.cmd       : core_side.cmd;
  assign ram.cmd_en    = use_loader ? loader.cmd_en    : core_side.cmd_en;
  assign ram.addr      = use_loader ? loader.addr      : core_side.addr;
  assign ram.wr_data   = use_loader ? loader.wr_data   : core_side.wr_data;
  assign ram.data_mask = use_loader ? loader.data_mask : core_side.data_mask;

  // read data to both, valid only to the owner
  assign loader.rd_data          = ram.rd_data;
  assign core_side.rd_data       = ram.rd_data;
  assign loader.rd_data_valid    = ram.rd_data_valid && (owner == OWN_LOADER);
  assign core_side.rd_data_valid = ram.rd_data_valid && (owner == OWN_RAMIO);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner    <= OWN_NONE;
      last_cmd <= BR_WRITE;
    end else if (ram.cmd_en) begin
      owner    <= use_loader ? OWN_LOADER : OWN_RAMIO;
      last_cmd <= ram.cmd;
    end else if (owner != OWN_NONE &&
                 (last_cmd == BR_WRITE || ram.rd_data_valid)) begin
      owner <= OWN_NONE;                      // write done or read returned
    end
  end

  // requesters must not strobe into an outstanding read
  a_one_read: assert property (
    @(posedge clk) disable iff (!arst_n)
    (owner != OWN_NONE && last_cmd == BR_READ) |-> !ram.cmd_en);

endmodule

/* rtl/burst_if.sv */
// ---------------------------------------------------------------------
// one burst ram channel: line command, write data, read return
// req/gnt let a requester wait for the shared ram
// ---------------------------------------------------------------------
`include "soc_defs.svh"

interface burst_if
  import burst_pkg::*;
();

  logic                       req;            // level, held until gnt
  logic                       gnt;            // pulse, strobe accepted
  br_cmd_e                    cmd;
  logic                       cmd_en;         // one-cycle strobe
  logic [`LINE_ADDR_BITS-1:0] addr;           // line index
  logic [`LINE_BYTES*8-1:0]   wr_data;
  logic [`LINE_BYTES-1:0]     data_mask;      // 1 = keep byte
  logic [`LINE_BYTES*8-1:0]   rd_data;
  logic                       rd_data_valid;

  modport master (output req, cmd, cmd_en, addr, wr_data, data_mask,
                  input  gnt, rd_data, rd_data_valid);
  modport slave  (input  req, cmd, cmd_en, addr, wr_data, data_mask,
                  output gnt, rd_data, rd_data_valid);

endinterface

/* rtl/burst_pkg.sv */
// ---------------------------------------------------------------------
// types of the burst ram side: command encoding and arbiter owner
// ---------------------------------------------------------------------
package burst_pkg;

  // same polarity as the psram controller
  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } br_cmd_e;

  // who holds the burst ram
  typedef enum logic [1:0] {
    OWN_NONE   = 2'd0,
    OWN_LOADER = 2'd1,
    OWN_RAMIO  = 2'd2
  } br_owner_e;

endpackage

/* rtl/burst_ram.sv */
// ---------------------------------------------------------------------
// behavioral stand-in for the psram controller
// 64-bit lines, writes land at once, reads return after fixed latency
// ---------------------------------------------------------------------
`include "soc_defs.svh"

module burst_ram
  import burst_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  burst_if.slave br
);

  localparam int LINES = 2 ** `LINE_ADDR_BITS;
  localparam int LAT   = `BR_READ_LATENCY;

  logic [`LINE_BYTES*8-1:0] mem [LINES];
  logic [`LINE_BYTES*8-1:0] data_pipe [LAT];
  logic [LAT-1:0]           vld_pipe;

  assign br.gnt           = br.req;            // single port, always ready
  assign br.rd_data       = data_pipe[LAT-1];
  assign br.rd_data_valid = vld_pipe[LAT-1];

  always_ff @(posedge clk) begin
    if (br.cmd_en && br.cmd == BR_WRITE) begin
      for (int i = 0; i < `LINE_BYTES; i++)
        if (!br.data_mask[i]) mem[br.addr][i*8 +: 8] <= br.wr_data[i*8 +: 8];
    end
    if (br.cmd_en) data_pipe[0] <= mem[br.addr];
    for (int i = 1; i < LAT; i++)
      data_pipe[i] <= data_pipe[i-1];
  end

  // read valid shift register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) vld_pipe <= '0;
    else         vld_pipe <= {vld_pipe[LAT-2:0], br.cmd_en && (br.cmd == BR_READ)};
  end

endmodule

/* rtl/flash_loader.sv */
// ---------------------------------------------------------------------
// boot copy from spi flash into burst ram, runs once after reset
// spi mode 0 at clk/2, read command 0x03, bytes packed little-endian
// ---------------------------------------------------------------------
`include "soc_defs.svh"

module flash_loader
  import burst_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  output logic    flash_cs_n,
  output logic    flash_clk,
  output logic    flash_mosi,
  input  logic    flash_miso,
  output logic    boot_done,
  burst_if.master br
);

  typedef enum logic [1:0] {LD_CMD, LD_BYTE, LD_LINE, LD_DONE} ld_state_e;

  ld_state_e                         state;
  logic [5:0]                        bit_cnt;
  logic [$clog2(`FLASH_BYTE_COUNT):0] byte_cnt;
  logic [31:0]                       cmd_sr;    // command then address
  logic [7:0]                        rx_byte;
  logic [`LINE_BYTES*8-1:0]          line_buf;
  logic [`LINE_ADDR_BITS-1:0]        line_idx;

  // full-line writes only
  assign br.req       = (state == LD_LINE);
  assign br.cmd_en    = br.req && br.gnt;
  assign br.cmd       = BR_WRITE;
  assign br.addr      = line_idx;
  assign br.wr_data   = line_buf;
  assign br.data_mask = '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= LD_CMD;
      flash_cs_n <= 1'b1;
      flash_clk  <= 1'b0;
      flash_mosi <= 1'b0;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      cmd_sr     <= {8'h03, `FLASH_SRC_ADDR};
      line_idx   <= '0;
      boot_done  <= 1'b0;
    end else begin
      case (state)
        LD_CMD: begin
          if (flash_cs_n) begin               // select, first bit out
            flash_cs_n <= 1'b0;
            flash_mosi <= cmd_sr[31];
            cmd_sr     <= cmd_sr << 1;
          end else begin
            flash_clk <= ~flash_clk;
            if (flash_clk) begin              // falling edge
              flash_mosi <= cmd_sr[31];
              cmd_sr     <= cmd_sr << 1;
              bit_cnt    <= bit_cnt + 1'b1;
              if (bit_cnt == 6'd31) begin
                bit_cnt <= '0;
                state   <= LD_BYTE;
              end
            end
          end
        end
        LD_BYTE: begin
          flash_clk <= ~flash_clk;
          if (!flash_clk) begin
            rx_byte <= {rx_byte[6:0], flash_miso};  // sample on rise, msb first
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt[2:0] == 3'd7) begin
              line_buf <= {rx_byte, line_buf[`LINE_BYTES*8-1:8]};
              byte_cnt <= byte_cnt + 1'b1;
              if (byte_cnt[2:0] == 3'd7)
                state <= LD_LINE;             // clock parks low, cs_n stays low
            end
          end
        end
        LD_LINE: begin
          if (br.gnt) begin
            line_idx <= line_idx + 1'b1;
            if (byte_cnt == `FLASH_BYTE_COUNT) begin
              state      <= LD_DONE;
              flash_cs_n <= 1'b1;
              boot_done  <= 1'b1;
            end else begin
              state <= LD_BYTE;
            end
          end
        end
        default: ;                            // done, idle forever
      endcase
    end
  end

  // loader is silent on the ram once the core may use it
  a_quiet_after_boot: assert property (
    @(posedge clk) disable iff (!arst_n) boot_done |-> !br.cmd_en);

endmodule

/* rtl/mem_top.sv */
// ---------------------------------------------------------------------
// memory subsystem top: flash boot loader, core port, arbiter, ram
// core drives the plain ramio ports once boot_done is high
// ---------------------------------------------------------------------
`include "soc_defs.svh"

module mem_top
  import ramio_pkg::*;
  import burst_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      enable,
  input  read_type_e                read_type,
  input  write_type_e               write_type,
  input  logic [`RAM_ADDR_BITS-1:0] address,
  input  logic [31:0]               data_in,
  output logic [31:0]               data_out,
  output logic                      data_out_ready,
  output logic                      busy,
  output logic                      boot_done,
  output logic                      flash_cs_n,
  output logic                      flash_clk,
  output logic                      flash_mosi,
  input  logic                      flash_miso
);

  ramio_if core_if ();
  burst_if ld_br ();   // loader to arbiter
  burst_if rio_br ();  // ramio to arbiter
  burst_if ram_br ();  // arbiter to ram

  // core port onto the interface
  assign core_if.enable     = enable;
  assign core_if.read_type  = read_type;
  assign core_if.write_type = write_type;
  assign core_if.address    = address;
  assign core_if.data_in    = data_in;
  assign data_out           = core_if.data_out;
  assign data_out_ready     = core_if.data_out_ready;
  assign busy               = core_if.busy;

  flash_loader flash_loader_inst (
    .clk,
    .arst_n,
    .flash_cs_n,
    .flash_clk,
    .flash_mosi,
    .flash_miso,
    .boot_done,
    .br(ld_br)
  );

  ramio ramio_inst (
    .clk,
    .arst_n,
    .boot_done,
    .core(core_if),
    .br  (rio_br)
  );

  burst_arbiter arb_inst (
    .clk,
    .arst_n,
    .loader   (ld_br),
    .core_side(rio_br),
    .ram      (ram_br)
  );

  burst_ram ram_inst (
    .clk,
    .arst_n,
    .br(ram_br)
  );

  // read data only comes back into an arbiter grant
  a_valid_owned: assert property (
    @(posedge clk) disable iff (!arst_n)
    ram_br.rd_data_valid |-> (arb_inst.owner != OWN_NONE));

endmodule

/* rtl/ramio.sv */
// ---------------------------------------------------------------------
// core access port onto the 64-bit burst ram
// every access reads its line; stores merge and write the line back
// ---------------------------------------------------------------------
`include "soc_defs.svh"

module ramio
  import ramio_pkg::*;
  import burst_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    boot_done,
  ramio_if.mem    core,
  burst_if.master br
);

  typedef enum logic [2:0] {
    RIO_IDLE, RIO_RD_REQ, RIO_WAIT, RIO_WR_REQ, RIO_FINISH
  } rio_state_e;

  rio_state_e                state;
  read_type_e                acc_rd;
  write_type_e               acc_wr;
  logic [`RAM_ADDR_BITS-1:0] acc_addr;
  logic [31:0]               acc_data;
  logic [`LINE_BYTES*8-1:0]  line_q;     // merged line for write-back
  logic [`LINE_BYTES*8-1:0]  lane_data;  // returned line, lane moved to bit 0
  logic [`LINE_BYTES*8-1:0]  wr_shift;   // store data moved to its lane
  logic [`LINE_BYTES-1:0]    wr_be;
  logic [`LINE_BYTES*8-1:0]  merged;
  logic [31:0]               rd_ext;
  logic                      half_acc;
  logic                      word_acc;
  logic                      misaligned;

  // ------------------------------------------------------------------
  // lane select and extension
  // ------------------------------------------------------------------
  assign lane_data = br.rd_data >> {acc_addr[2:0], 3'b000};

  always_comb begin
    case (acc_rd)
      RD_BYTE:   rd_ext = {{24{lane_data[7]}}, lane_data[7:0]};
      RD_HALF:   rd_ext = {{16{lane_data[15]}}, lane_data[15:0]};
      RD_BYTE_U: rd_ext = {24'b0, lane_data[7:0]};
      RD_HALF_U: rd_ext = {16'b0, lane_data[15:0]};
      default:   rd_ext = lane_data[31:0];
    endcase
  end

  // store merge into the line just read
  assign wr_shift = {32'b0, acc_data} << {acc_addr[2:0], 3'b000};

  always_comb begin
    case (acc_wr)
      WR_BYTE: wr_be = 8'h01 << acc_addr[2:0];
      WR_HALF: wr_be = 8'h03 << acc_addr[2:0];
      default: wr_be = 8'h0f << acc_addr[2:0];
    endcase
    for (int i = 0; i < `LINE_BYTES; i++)
      merged[i*8 +: 8] = wr_be[i] ? wr_shift[i*8 +: 8] : br.rd_data[i*8 +: 8];
  end

  // ------------------------------------------------------------------
  // burst requests
  // ------------------------------------------------------------------
  assign br.req       = (state == RIO_RD_REQ) || (state == RIO_WR_REQ);
  assign br.cmd_en    = br.req && br.gnt;
  assign br.cmd       = (state == RIO_WR_REQ) ? BR_WRITE : BR_READ;
  assign br.addr      = acc_addr[`RAM_ADDR_BITS-1:3];
  assign br.wr_data   = line_q;
  assign br.data_mask = '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state               <= RIO_IDLE;
      acc_rd              <= RD_NONE;
      acc_wr              <= WR_NONE;
      core.busy           <= 1'b0;
      core.data_out_ready <= 1'b0;
    end else begin
      core.data_out_ready <= 1'b0;
      case (state)
        RIO_IDLE: begin
          if (core.enable && boot_done) begin
            acc_rd    <= core.read_type;
            acc_wr    <= core.write_type;
            acc_addr  <= core.address;
            acc_data  <= core.data_in;
            core.busy <= 1'b1;
            state     <= RIO_RD_REQ;
          end
        end
        RIO_RD_REQ: if (br.gnt) state <= RIO_WAIT;
        RIO_WAIT: begin
          if (br.rd_data_valid) begin
            if (acc_wr != WR_NONE) begin
              line_q <= merged;
              state  <= RIO_WR_REQ;
            end else begin
              core.data_out <= rd_ext;
              state         <= RIO_FINISH;
            end
          end
        end
        RIO_WR_REQ: if (br.gnt) state <= RIO_FINISH;
        RIO_FINISH: begin                     // ready pulse with busy falling
          core.busy           <= 1'b0;
          core.data_out_ready <= 1'b1;
          state               <= RIO_IDLE;
        end
        default: state <= RIO_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // core protocol checks
  // ------------------------------------------------------------------
  assign half_acc   = (core.read_type inside {RD_HALF, RD_HALF_U}) ||
                      (core.write_type == WR_HALF);
  assign word_acc   = (core.read_type == RD_WORD) || (core.write_type == WR_WORD);
  assign misaligned = (half_acc && core.address[0]) ||
                      (word_acc && (core.address[1:0] != 2'b00));

  a_aligned: assert property (
    @(posedge clk) disable iff (!arst_n) core.enable |-> !misaligned);
  a_not_busy: assert property (
    @(posedge clk) disable iff (!arst_n) core.enable |-> !core.busy);
  a_after_boot: assert property (
    @(posedge clk) disable iff (!arst_n) core.enable |-> boot_done);

endmodule

/* rtl/ramio_if.sv */
// ---------------------------------------------------------------------
// core to ramio access bundle
// core side drives the request, mem side answers with data and busy
// ---------------------------------------------------------------------
`include "soc_defs.svh"

interface ramio_if
  import ramio_pkg::*;
();

  logic                      enable;          // one-cycle strobe
  read_type_e                read_type;
  write_type_e               write_type;
  logic [`RAM_ADDR_BITS-1:0] address;         // naturally aligned
  logic [31:0]               data_in;
  logic [31:0]               data_out;
  logic                      data_out_ready;  // pulses as busy falls
  logic                      busy;

  modport core (output enable, read_type, write_type, address, data_in,
                input  data_out, data_out_ready, busy);
  modport mem  (input  enable, read_type, write_type, address, data_in,
                output data_out, data_out_ready, busy);

endinterface

/* rtl/ramio_pkg.sv */
// ---------------------------------------------------------------------
// access types seen on the core side of ramio
// bit 2 of the read type marks a zero-extended load
// ---------------------------------------------------------------------
package ramio_pkg;

  // load width and extension
  typedef enum logic [2:0] {
    RD_NONE   = 3'b000,
    RD_BYTE   = 3'b001,  // sign extended
    RD_HALF   = 3'b010,  // sign extended
    RD_WORD   = 3'b011,
    RD_BYTE_U = 3'b101,  // zero extended
    RD_HALF_U = 3'b110   // zero extended
  } read_type_e;

  // store width
  typedef enum logic [1:0] {
    WR_NONE = 2'b00,
    WR_BYTE = 2'b01,
    WR_HALF = 2'b10,
    WR_WORD = 2'b11
  } write_type_e;

endpackage

/* rtl/soc_defs.svh */
// ---------------------------------------------------------------------
// sizes shared by the memory subsystem and its testbench
// include wherever a bus width or the boot block layout is needed
// ---------------------------------------------------------------------
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// ram geometry
`define RAM_ADDR_BITS 12                        // byte address, 4 KiB
`define LINE_BYTES 8                            // one burst line
`define LINE_ADDR_BITS (`RAM_ADDR_BITS - 3)     // line index width

// cycles from read cmd_en to rd_data_valid
`define BR_READ_LATENCY 4

// boot block in spi flash, copied to ram address 0
`define FLASH_SRC_ADDR 24'h00_1000
`define FLASH_BYTE_COUNT 64                     // multiple of LINE_BYTES

`endif

/* run.sh */
#!/usr/bin/env bash
# build tb_mem_top with verilator, run it, decide on the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_top -f project.f \
  && ./obj_dir/Vtb_mem_top | tee sim.log \
  || { echo "build or simulation failed"; exit 1; }
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1

/* tests/tb_mem_top.sv */
// ----------------------------------------------------------------------
// testbench for mem_top with an spi flash model, a boot check and random
// core accesses against a byte-wide reference memory
// ----------------------------------------------------------------------
`include "soc_defs.svh"

module tb_mem_top
  import ramio_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LAT        = `BR_READ_LATENCY;
  localparam int RAND_ITERS = 150;
  localparam int EXT_ITERS  = 8;
  localparam int N_ACCESS   = `FLASH_BYTE_COUNT / 4 + 48 + 2 * RAND_ITERS + 6 * EXT_ITERS;
  localparam int CYCLE_LIMIT = 200 * N_ACCESS + 40 * `FLASH_BYTE_COUNT + 1000;

  logic                      clk = 1'b0;
  logic                      arst_n;
  logic                      enable;
  read_type_e                read_type;
  write_type_e               write_type;
  logic [`RAM_ADDR_BITS-1:0] address;
  logic [31:0]               data_in;
  logic [31:0]               data_out;
  logic                      data_out_ready;
  logic                      busy;
  logic                      boot_done;
  logic                      flash_cs_n;
  logic                      flash_clk;
  logic                      flash_mosi;
  logic                      flash_miso = 1'b0;

  logic [7:0]  boot_rom [`FLASH_BYTE_COUNT];     // flash contents at FLASH_SRC_ADDR
  logic [7:0]  ref_mem [2**`RAM_ADDR_BITS];      // expected ram bytes
  logic [31:0] flash_cmd = '0;                   // command + address seen on mosi
  int          flash_bits = 0;                   // rising flash_clk edges
  int          errors = 0;
  int          n_access = 0;
  int          cycle_cnt = 0;

  always #5 clk = ~clk;

  mem_top mem_top_inst (.*);

  // ----------------------------------------------------------------------
  // spi flash model in mode 0
  // ----------------------------------------------------------------------
  always @(posedge flash_clk) begin
    if (!flash_cs_n) begin
      if (flash_bits < 32) flash_cmd <= {flash_cmd[30:0], flash_mosi};
      flash_bits <= flash_bits + 1;
    end
  end

  // next data bit goes out msb first after the falling edge
  always @(negedge flash_clk) begin
    if (!flash_cs_n && flash_bits >= 32 && (flash_bits - 32) / 8 < `FLASH_BYTE_COUNT)
      flash_miso = boot_rom[(flash_bits - 32) / 8][7 - (flash_bits - 32) % 8];
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles, %0d errors so far",
               CYCLE_LIMIT, errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  // one core access with checks of the busy and ready handshake
  task automatic run_access(input read_type_e rt, input write_type_e wt,
                            input int unsigned addr, input logic [31:0] din,
                            output logic [31:0] dout);
    int busy_cycles;
    busy_cycles = 0;
    @(negedge clk);
    enable     = 1'b1;
    read_type  = rt;
    write_type = wt;
    address    = addr[`RAM_ADDR_BITS-1:0];
    data_in    = din;
    @(negedge clk);
    enable     = 1'b0;              // strobe is one cycle
    read_type  = RD_NONE;
    write_type = WR_NONE;
    if (!busy) begin
      errors++;
      $display("FAILED %0t: busy low the cycle after enable, addr %03h", $time, addr);
    end
    while (busy) begin
      busy_cycles++;
      if (data_out_ready) begin
        errors++;
        $display("FAILED %0t: data_out_ready high while busy", $time);
      end
      @(negedge clk);
    end
    if (!data_out_ready) begin
      errors++;
      $display("FAILED %0t: no data_out_ready as busy fell", $time);
    end
    if (rt != RD_NONE && busy_cycles < LAT + 2) begin
      errors++;
      $display("FAILED %0t: read busy for %0d cycles, minimum %0d", $time,
               busy_cycles, LAT + 2);
    end
    dout = data_out;
    @(negedge clk);
    if (data_out_ready) begin       // single pulse only
      errors++;
      $display("FAILED %0t: data_out_ready longer than one cycle", $time);
    end
    n_access++;
  endtask

  task automatic store_model(input write_type_e wt, input int unsigned addr,
                             input logic [31:0] data);
    ref_mem[addr] = data[7:0];
    if (wt != WR_BYTE) ref_mem[addr + 1] = data[15:8];
    if (wt == WR_WORD) begin
      ref_mem[addr + 2] = data[23:16];
      ref_mem[addr + 3] = data[31:24];
    end
  endtask

  // expected load result from little-endian bytes with extension by type
  function automatic logic [31:0] load_model(input read_type_e rt, input int unsigned addr);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = ref_mem[addr];
    b1 = (rt == RD_BYTE || rt == RD_BYTE_U) ? 8'h00 : ref_mem[addr + 1];
    case (rt)
      RD_BYTE:   return {{24{b0[7]}}, b0};
      RD_BYTE_U: return {24'h0, b0};
      RD_HALF:   return {{16{b1[7]}}, b1, b0};
      RD_HALF_U: return {16'h0, b1, b0};
      default:   return {ref_mem[addr + 3], ref_mem[addr + 2], b1, b0};
    endcase
  endfunction

  function automatic read_type_e pick_read(input int unsigned sel);
    case (sel % 5)
      0:       return RD_BYTE;
      1:       return RD_BYTE_U;
      2:       return RD_HALF;
      3:       return RD_HALF_U;
      default: return RD_WORD;
    endcase
  endfunction

  function automatic write_type_e pick_write(input int unsigned sel);
    case (sel % 3)
      0:       return WR_BYTE;
      1:       return WR_HALF;
      default: return WR_WORD;
    endcase
  endfunction

  // natural alignment for a 1, 2 or 4 byte access
  function automatic int unsigned align(input int unsigned addr, input int unsigned size);
    return addr & ~(size - 1);
  endfunction

  // top bit set so sign and zero extension differ
  task automatic extension_test(input bit is_half);
    int unsigned addr;
    logic [31:0] val;
    logic [31:0] got;
    addr = 64 + $urandom_range(191, 0);
    if (is_half) begin
      addr = align(addr, 2);
      val  = 32'h8000 | $urandom_range(32'h7fff, 0);
      run_access(RD_NONE, WR_HALF, addr, val, got);
      store_model(WR_HALF, addr, val);
      run_access(RD_HALF, WR_NONE, addr, '0, got);
      compare("signed half", got, {16'hffff, val[15:0]});
      run_access(RD_HALF_U, WR_NONE, addr, '0, got);
      compare("unsigned half", got, {16'h0000, val[15:0]});
    end else begin
      val = 32'h80 | $urandom_range(32'h7f, 0);
      run_access(RD_NONE, WR_BYTE, addr, val, got);
      store_model(WR_BYTE, addr, val);
      run_access(RD_BYTE, WR_NONE, addr, '0, got);
      compare("signed byte", got, {24'hffffff, val[7:0]});
      run_access(RD_BYTE_U, WR_NONE, addr, '0, got);
      compare("unsigned byte", got, {24'h000000, val[7:0]});
    end
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    int unsigned addr;
    logic [31:0] val;
    logic [31:0] got;
    read_type_e  rt;
    write_type_e wt;
    arst_n     = 1'b0;
    enable     = 1'b0;
    read_type  = RD_NONE;
    write_type = WR_NONE;
    address    = '0;
    data_in    = '0;
    void'($urandom(69));
    for (int i = 0; i < 2**`RAM_ADDR_BITS; i++) ref_mem[i] = 8'h00;
    for (int i = 0; i < `FLASH_BYTE_COUNT; i++) begin
      boot_rom[i] = 8'($urandom_range(255, 0));
      ref_mem[i]  = boot_rom[i];              // boot block lands at address 0
    end

    repeat (16) @(negedge clk);
    if (busy || data_out_ready || boot_done || !flash_cs_n || flash_clk) begin
      errors++;
      $display("FAILED %0t: outputs not idle in reset", $time);
    end
    arst_n = 1'b1;

    // boot copy
    while (!boot_done) @(negedge clk);
    compare("flash command", flash_cmd, {8'h03, `FLASH_SRC_ADDR});
    compare("flash clock count", 32'(flash_bits), 32'(32 + 8 * `FLASH_BYTE_COUNT));

    for (int i = 0; i < `FLASH_BYTE_COUNT; i += 4) begin
      run_access(RD_WORD, WR_NONE, i, '0, got);
      compare("boot word", got,
              {boot_rom[i + 3], boot_rom[i + 2], boot_rom[i + 1], boot_rom[i]});
    end

    // fill lines 8 to 31 so every later read sees defined data
    for (int a = 64; a < 256; a += 4) begin
      val = $urandom();
      run_access(RD_NONE, WR_WORD, a, val, got);
      store_model(WR_WORD, a, val);
    end

    // random store followed by a load somewhere in the same line
    for (int i = 0; i < RAND_ITERS; i++) begin
      wt   = pick_write($urandom_range(2, 0));
      addr = align($urandom_range(255, 0), (wt == WR_WORD) ? 4 : (wt == WR_HALF) ? 2 : 1);
      val  = $urandom();
      run_access(RD_NONE, wt, addr, val, got);
      store_model(wt, addr, val);
      rt   = pick_read($urandom_range(4, 0));
      addr = (addr & ~32'd7) | $urandom_range(7, 0);
      addr = align(addr, (rt == RD_WORD) ? 4 : (rt inside {RD_HALF, RD_HALF_U}) ? 2 : 1);
      run_access(rt, WR_NONE, addr, '0, got);
      compare("random load", got, load_model(rt, addr));
    end

    for (int i = 0; i < EXT_ITERS; i++) begin
      extension_test(1'b0);
      extension_test(1'b1);
    end

    $display("done: %0d accesses, %0d errors", n_access, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
